//--- project.f
common/lsu_pkg.sv
lsu/store_ring_buffer.sv
lsu/load_align.sv
lsu/mem_unit.sv
rtl/lsu_top.sv
dv/wb_mem_model.sv
dv/tb_lsu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --timing
TOP       := tb_lsu
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_lsu.sv
module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam word_t FILL_PATTERN = 32'h9E37_79B1;
    localparam int    OP_TIMEOUT   = 100;
    localparam int    QUIET_CYCLES = 8;

    typedef struct packed {
        logic   is_store;
        memop_t memop;
        addr_t  base;
        word_t  imm;
        word_t  wdata;
        tag_t   tag;
        logic   fwd;
    } op_entry_t;

    logic   clk;
    logic   rst;
    logic   op_valid;
    logic   op_is_store;
    memop_t op_memop;
    addr_t  op_base;
    word_t  op_imm;
    word_t  op_wdata;
    tag_t   op_tag;
    logic   op_ready;
    logic   res_valid;
    tag_t   res_tag;
    word_t  res_rdata;
    logic   wb_cyc;
    logic   wb_stb;
    logic   wb_we;
    addr_t  wb_adr;
    mask_t  wb_sel;
    word_t  wb_dat_w;
    word_t  wb_dat_r;
    logic   wb_ack;

    op_entry_t  ops[$];
    logic [7:0] ref_mem [1024];
    int         error_count;
    int         check_count;
    logic       timed_out;

    always #20 clk = ~clk;

    lsu_top dut (
        .clk (clk), .rst (rst),
        .op_valid_i (op_valid), .op_is_store_i (op_is_store), .op_memop_i (op_memop),
        .op_base_i (op_base), .op_imm_i (op_imm), .op_wdata_i (op_wdata),
        .op_tag_i (op_tag), .op_ready_o (op_ready),
        .res_valid_o (res_valid), .res_tag_o (res_tag), .res_rdata_o (res_rdata),
        .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
        .wb_sel_o (wb_sel), .wb_dat_o (wb_dat_w), .wb_dat_i (wb_dat_r), .wb_ack_i (wb_ack)
    );

    wb_mem_model #(.FILL_PATTERN (FILL_PATTERN)) mem_model (
        .clk (clk), .rst (rst), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
        .wb_adr_i (wb_adr), .wb_sel_i (wb_sel), .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack)
    );

    task automatic add_op(input logic is_store, input memop_t memop, input addr_t base,
                          input word_t imm, input word_t wdata, input logic fwd);
        op_entry_t e;

        e.is_store = is_store;
        e.memop    = memop;
        e.base     = base;
        e.imm      = imm;
        e.wdata    = wdata;
        e.tag      = tag_t'(ops.size());
        e.fwd      = fwd;
        ops.push_back(e);
    endtask

    task automatic build_table();
        // preloaded words at every byte and half offset
        for (int off = 0; off < 4; off++) begin
            add_op(1'b0, MEMOP_B,  32'h40, word_t'(4 + off), '0, 1'b0);
            add_op(1'b0, MEMOP_BU, 32'h40, word_t'(4 + off), '0, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            add_op(1'b0, MEMOP_H,  32'h48, word_t'(off), '0, 1'b0);
            add_op(1'b0, MEMOP_HU, 32'h48, word_t'(off), '0, 1'b0);
        end
        add_op(1'b0, MEMOP_W, 32'h60,  32'hFFFF_FFF8, '0, 1'b0);
        add_op(1'b0, MEMOP_W, 32'h3F0, 32'h0000_000C, '0, 1'b0);
        // full-word hits in the store buffer
        add_op(1'b1, MEMOP_W,  32'h80, 32'h0, 32'hDEAD_BEEF, 1'b0);
        add_op(1'b0, MEMOP_W,  32'h80, 32'h0, '0, 1'b1);
        add_op(1'b1, MEMOP_W,  32'h84, 32'h0, 32'h8091_A2B3, 1'b0);
        add_op(1'b0, MEMOP_B,  32'h84, 32'h1, '0, 1'b1);
        add_op(1'b0, MEMOP_HU, 32'h84, 32'h2, '0, 1'b1);
        // partial lanes merged with bus data, youngest lane wins
        add_op(1'b1, MEMOP_B,  32'hC0, 32'h1, 32'h0000_005A, 1'b0);
        add_op(1'b0, MEMOP_W,  32'hC0, 32'h0, '0, 1'b0);
        add_op(1'b1, MEMOP_H,  32'hD0, 32'h2, 32'h0000_1234, 1'b0);
        add_op(1'b1, MEMOP_B,  32'hD0, 32'h3, 32'h0000_0077, 1'b0);
        add_op(1'b0, MEMOP_W,  32'hD0, 32'h0, '0, 1'b0);
        add_op(1'b0, MEMOP_HU, 32'hD0, 32'h2, '0, 1'b0);
        // burst longer than the buffer
        add_op(1'b1, MEMOP_W,  32'h100, 32'h0, 32'h1122_3344, 1'b0);
        add_op(1'b1, MEMOP_B,  32'h100, 32'h5, 32'h0000_00A5, 1'b0);
        add_op(1'b1, MEMOP_H,  32'h100, 32'hA, 32'h0000_BEEF, 1'b0);
        add_op(1'b1, MEMOP_W,  32'h100, 32'hC, 32'hCAFE_F00D, 1'b0);
        add_op(1'b1, MEMOP_B,  32'h100, 32'h3, 32'h0000_0080, 1'b0);
        add_op(1'b1, MEMOP_H,  32'h104, 32'hFFFF_FFFC, 32'h0000_7E01, 1'b0);
        add_op(1'b0, MEMOP_W,  32'h100, 32'h0, '0, 1'b0);
        add_op(1'b0, MEMOP_B,  32'h100, 32'h3, '0, 1'b0);
        add_op(1'b0, MEMOP_H,  32'h108, 32'h2, '0, 1'b0);
        add_op(1'b0, MEMOP_W,  32'h104, 32'h0, '0, 1'b0);
    endtask

    task automatic store_ref(input memop_t memop, input addr_t addr, input word_t wdata);
        int idx;

        idx = int'(addr[9:0]);
        case (memop)
            MEMOP_B: ref_mem[idx] = wdata[7:0];
            MEMOP_H: begin
                ref_mem[idx]     = wdata[7:0];
                ref_mem[idx + 1] = wdata[15:8];
            end
            default: begin
                for (int j = 0; j < 4; j++) begin
                    ref_mem[idx + j] = wdata[8*j +: 8];
                end
            end
        endcase
    endtask

    // little endian bytes, sign or zero fill by access width
    function automatic word_t expect_load(input memop_t memop, input addr_t addr);
        int         idx;
        logic [7:0] b0;
        logic [7:0] b1;

        idx = int'(addr[9:0]);
        b0  = ref_mem[idx];
        b1  = ref_mem[idx + 1];
        case (memop)
            MEMOP_B:  return {{24{b0[7]}}, b0};
            MEMOP_BU: return {24'h000000, b0};
            MEMOP_H:  return {{16{b1[7]}}, b1, b0};
            MEMOP_HU: return {16'h0000, b1, b0};
            default:  return {ref_mem[idx + 3], ref_mem[idx + 2], b1, b0};
        endcase
    endfunction

    task automatic apply_op(input op_entry_t e);
        int    waited;
        logic  saw_read;
        addr_t addr;
        word_t expected;

        addr     = e.base + e.imm;
        expected = '0;
        @(posedge clk);
        #1;
        op_valid    = 1'b1;
        op_is_store = e.is_store;
        op_memop    = e.memop;
        op_base     = e.base;
        op_imm      = e.imm;
        op_wdata    = e.wdata;
        op_tag      = e.tag;
        waited      = 0;
        @(negedge clk);
        while (!op_ready && waited < OP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!op_ready) begin
            $display("timeout: op_ready never rose for tag %0d", e.tag);
            error_count++;
            timed_out = 1'b1;
            op_valid  = 1'b0;
            return;
        end
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        if (e.is_store) begin
            store_ref(e.memop, addr, e.wdata);
        end else begin
            expected = expect_load(e.memop, addr);
        end
        waited = 0;
        @(negedge clk);
        saw_read = wb_cyc && !wb_we;
        while (!res_valid && waited < OP_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (wb_cyc && !wb_we) begin
                saw_read = 1'b1;
            end
        end
        if (!res_valid) begin
            $display("timeout: no result for tag %0d", e.tag);
            error_count++;
            timed_out = 1'b1;
            return;
        end
        check_count++;
        if (e.fwd && (waited != 0 || saw_read)) begin
            $display("forwarded load tag %0d was late by %0d cycles or used the bus",
                     e.tag, waited);
            error_count++;
        end
        if (res_tag !== e.tag) begin
            $display("mismatch at %0t: result tag %0d, expected %0d", $time, res_tag, e.tag);
            error_count++;
        end
        if (res_rdata !== expected) begin
            $display("mismatch at %0t: tag %0d addr %08h rdata %08h, expected %08h",
                     $time, e.tag, addr, res_rdata, expected);
            error_count++;
        end
    endtask

    // drained once the bus stays quiet for a while
    task automatic wait_bus_idle();
        int quiet;
        int waited;

        quiet  = 0;
        waited = 0;
        while (quiet < QUIET_CYCLES && waited < 10 * OP_TIMEOUT) begin
            @(negedge clk);
            waited++;
            quiet = wb_cyc ? 0 : quiet + 1;
        end
        if (quiet < QUIET_CYCLES) begin
            $display("timeout: Wishbone bus never went idle");
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_memory();
        word_t expected;

        for (int i = 0; i < 256; i++) begin
            expected = {ref_mem[4*i + 3], ref_mem[4*i + 2], ref_mem[4*i + 1], ref_mem[4*i]};
            check_count++;
            if (mem_model.mem[i] !== expected) begin
                $display("mismatch at %0t: memory word %0d is %08h, expected %08h",
                         $time, i, mem_model.mem[i], expected);
                error_count++;
            end
        end
    endtask

    initial begin
        word_t w;

        clk         = 1'b0;
        rst         = 1'b1;
        op_valid    = 1'b0;
        op_is_store = 1'b0;
        op_memop    = MEMOP_W;
        op_base     = '0;
        op_imm      = '0;
        op_wdata    = '0;
        op_tag      = '0;
        error_count = 0;
        check_count = 0;
        timed_out   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            w = word_t'(i) * FILL_PATTERN;
            for (int j = 0; j < 4; j++) begin
                ref_mem[4*i + j] = w[8*j +: 8];
            end
        end
        build_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_count++;
        if (!op_ready || wb_cyc || wb_stb || wb_we || res_valid) begin
            $display("mismatch at %0t: after reset ready %b cyc %b stb %b we %b res_valid %b",
                     $time, op_ready, wb_cyc, wb_stb, wb_we, res_valid);
            error_count++;
        end
        foreach (ops[i]) begin
            if (!timed_out) begin
                apply_op(ops[i]);
            end
        end
        if (!timed_out) begin
            wait_bus_idle();
        end
        if (!timed_out) begin
            check_memory();
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- dv/wb_mem_model.sv
module wb_mem_model #(
    parameter lsu_pkg::word_t FILL_PATTERN = 32'h9E37_79B1
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           wb_cyc_i,
    input  logic           wb_stb_i,
    input  logic           wb_we_i,
    input  lsu_pkg::addr_t wb_adr_i,
    input  lsu_pkg::mask_t wb_sel_i,
    input  lsu_pkg::word_t wb_dat_i,
    output lsu_pkg::word_t wb_dat_o,
    output logic           wb_ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    word_t      mem [256];
    word_t      rdata_q = '0;
    logic       ack_q   = 1'b0;
    logic       busy_q;
    logic [1:0] wait_q;
    integer     seed    = 20;

    assign wb_dat_o = rdata_q;
    assign wb_ack_o = ack_q;

    // one cycle to latch the request, then 0 to 3 random wait cycles
    always @(posedge clk) begin
        logic [7:0] idx;
        integer     draw;

        idx = wb_adr_i[9:2];
        if (rst) begin
            ack_q  <= 1'b0;
            busy_q <= 1'b0;
            wait_q <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= word_t'(i) * FILL_PATTERN;
            end
        end else begin
            ack_q <= 1'b0;
            if (wb_cyc_i && wb_stb_i && !ack_q) begin
                if (!busy_q) begin
                    draw   = $random(seed);
                    wait_q <= draw[1:0];
                    busy_q <= 1'b1;
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    busy_q <= 1'b0;
                    ack_q  <= 1'b1;
                    if (wb_we_i) begin
                        for (int j = 0; j < 4; j++) begin
                            if (wb_sel_i[j]) begin
                                mem[idx][8*j +: 8] <= wb_dat_i[8*j +: 8];
                            end
                        end
                    end else begin
                        rdata_q <= mem[idx];
                    end
                end
            end
        end
    end

endmodule

//--- rtl/lsu_top.sv
module lsu_top (
    input  logic             clk,
    input  logic             rst,

    input  logic             op_valid_i,
    input  logic             op_is_store_i,
    input  lsu_pkg::memop_t  op_memop_i,
    input  lsu_pkg::addr_t   op_base_i,
    input  lsu_pkg::word_t   op_imm_i,
    input  lsu_pkg::word_t   op_wdata_i,
    input  lsu_pkg::tag_t    op_tag_i,
    output logic             op_ready_o,

    output logic             res_valid_o,
    output lsu_pkg::tag_t    res_tag_o,
    output lsu_pkg::word_t   res_rdata_o,

    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output logic             wb_we_o,
    output lsu_pkg::addr_t   wb_adr_o,
    output lsu_pkg::mask_t   wb_sel_o,
    output lsu_pkg::word_t   wb_dat_o,
    input  lsu_pkg::word_t   wb_dat_i,
    input  logic             wb_ack_i
);

    mem_unit u_mem_unit (
        .clk           (clk),
        .rst           (rst),
        .op_valid_i    (op_valid_i),
        .op_is_store_i (op_is_store_i),
        .op_memop_i    (op_memop_i),
        .op_base_i     (op_base_i),
        .op_imm_i      (op_imm_i),
        .op_wdata_i    (op_wdata_i),
        .op_tag_i      (op_tag_i),
        .op_ready_o    (op_ready_o),
        .res_valid_o   (res_valid_o),
        .res_tag_o     (res_tag_o),
        .res_rdata_o   (res_rdata_o),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_we_o       (wb_we_o),
        .wb_adr_o      (wb_adr_o),
        .wb_sel_o      (wb_sel_o),
        .wb_dat_o      (wb_dat_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i)
    );

endmodule

//--- lsu/mem_unit.sv
module mem_unit (
    input  logic             clk,
    input  logic             rst,

    input  logic             op_valid_i,
    input  logic             op_is_store_i,
    input  lsu_pkg::memop_t  op_memop_i,
    input  lsu_pkg::addr_t   op_base_i,
    input  lsu_pkg::word_t   op_imm_i,
    input  lsu_pkg::word_t   op_wdata_i,
    input  lsu_pkg::tag_t    op_tag_i,
    output logic             op_ready_o,

    output logic             res_valid_o,
    output lsu_pkg::tag_t    res_tag_o,
    output lsu_pkg::word_t   res_rdata_o,

    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output logic             wb_we_o,
    output lsu_pkg::addr_t   wb_adr_o,
    output lsu_pkg::mask_t   wb_sel_o,
    output lsu_pkg::word_t   wb_dat_o,
    input  lsu_pkg::word_t   wb_dat_i,
    input  logic             wb_ack_i
);
    import lsu_pkg::*;

    lsu_state_e state_q;

    addr_t  agen_addr;
    addr_t  agen_word;
    addr_t  addr_q;
    addr_t  lookup_addr;
    memop_t memop_q;
    tag_t   tag_q;

    logic   op_fire;
    logic   store_fire;
    logic   load_fire;
    logic   fwd_full;
    logic   drain_start;

    logic   sb_enq;
    logic   sb_deq;
    logic   sb_full;
    logic   sb_empty;
    logic   sb_hit;
    addr_t  head_addr;
    word_t  head_wdata;
    mask_t  head_wmask;
    word_t  hit_wdata;
    mask_t  hit_wmask;

    logic [1:0] al_off;
    memop_t     al_memop;
    word_t      al_rdata;
    word_t      load_data;
    word_t      store_data;
    mask_t      lane_mask;
    word_t      merged_rdata;

    assign agen_addr = op_base_i + op_imm_i;
    assign agen_word = {agen_addr[31:2], 2'b00};

    // stores only need a free slot
    assign op_ready_o  = (state_q == S_IDLE) && (!op_is_store_i || !sb_full);
    assign op_fire     = op_valid_i && op_ready_o;
    assign store_fire  = op_fire && op_is_store_i;
    assign load_fire   = op_fire && !op_is_store_i;
    assign fwd_full    = sb_hit && (hit_wmask == 4'b1111);
    assign drain_start = (state_q == S_IDLE) && !sb_empty && !op_fire;

    assign sb_enq      = store_fire;
    assign sb_deq      = (state_q == S_DRAIN_WAIT) && wb_ack_i;
    // buffer contents stay fixed while a load waits on the bus
    assign lookup_addr = (state_q == S_IDLE) ? agen_word : {addr_q[31:2], 2'b00};

    assign res_valid_o = (state_q == S_RESULT);
    assign res_tag_o   = tag_q;

    store_ring_buffer #(
        .DEPTH         (SB_DEPTH)
    ) u_store_buf (
        .clk           (clk),
        .rst           (rst),
        .enq_i         (sb_enq),
        .enq_addr_i    (agen_word),
        .enq_wdata_i   (store_data),
        .enq_wmask_i   (lane_mask),
        .deq_i         (sb_deq),
        .head_addr_o   (head_addr),
        .head_wdata_o  (head_wdata),
        .head_wmask_o  (head_wmask),
        .full_o        (sb_full),
        .empty_o       (sb_empty),
        .lookup_addr_i (lookup_addr),
        .hit_o         (sb_hit),
        .hit_wdata_o   (hit_wdata),
        .hit_wmask_o   (hit_wmask)
    );

    // buffered lanes override bus data
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            if (sb_hit && hit_wmask[j]) begin
                merged_rdata[8*j +: 8] = hit_wdata[8*j +: 8];
            end else begin
                merged_rdata[8*j +: 8] = wb_dat_i[8*j +: 8];
            end
        end
    end

    // idle aligns the incoming op, otherwise the one in flight
    always_comb begin
        if (state_q == S_IDLE) begin
            al_off   = agen_addr[1:0];
            al_memop = op_memop_i;
            al_rdata = hit_wdata;
        end else begin
            al_off   = addr_q[1:0];
            al_memop = memop_q;
            al_rdata = merged_rdata;
        end
    end

    load_align u_align (
        .byte_off_i (al_off),
        .memop_i    (al_memop),
        .rdata_i    (al_rdata),
        .sdata_i    (op_wdata_i),
        .rdata_o    (load_data),
        .sdata_o    (store_data),
        .mask_o     (lane_mask)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= S_IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (store_fire || (load_fire && fwd_full)) begin
                        state_q <= S_RESULT;
                    end else if (load_fire) begin
                        state_q  <= S_LOAD_WAIT;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= 1'b0;
                    end else if (drain_start) begin
                        state_q  <= S_DRAIN_WAIT;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= 1'b1;
                    end
                end
                S_LOAD_WAIT: begin
                    if (wb_ack_i) begin
                        state_q  <= S_RESULT;
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                    end
                end
                S_DRAIN_WAIT: begin
                    if (wb_ack_i) begin
                        state_q  <= S_IDLE;
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        wb_we_o  <= 1'b0;
                    end
                end
                S_RESULT: state_q <= S_IDLE;
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    // accepted op, result word and bus payload
    always_ff @(posedge clk) begin
        if (op_fire) begin
            addr_q  <= agen_addr;
            memop_q <= op_memop_i;
            tag_q   <= op_tag_i;
        end

        if (store_fire) begin
            res_rdata_o <= '0;
        end else if ((load_fire && fwd_full) || (state_q == S_LOAD_WAIT && wb_ack_i)) begin
            res_rdata_o <= load_data;
        end

        if (load_fire) begin
            wb_adr_o <= agen_word;
            wb_sel_o <= lane_mask;
            wb_dat_o <= '0;
        end else if (drain_start) begin
            wb_adr_o <= head_addr;
            wb_sel_o <= head_wmask;
            wb_dat_o <= head_wdata;
        end
    end

endmodule

//--- lsu/load_align.sv
module load_align (
    input  logic [1:0]      byte_off_i,
    input  lsu_pkg::memop_t memop_i,
    input  lsu_pkg::word_t  rdata_i,
    input  lsu_pkg::word_t  sdata_i,
    output lsu_pkg::word_t  rdata_o,
    output lsu_pkg::word_t  sdata_o,
    output lsu_pkg::mask_t  mask_o
);
    import lsu_pkg::*;

    word_t rshift;
    mask_t lane_mask;

    // addressed byte or half brought down to lane 0
    assign rshift = rdata_i >> {byte_off_i, 3'b000};

    always_comb begin
        case (memop_i)
            MEMOP_B:  rdata_o = {{24{rshift[7]}}, rshift[7:0]};
            MEMOP_BU: rdata_o = {24'h000000, rshift[7:0]};
            MEMOP_H:  rdata_o = {{16{rshift[15]}}, rshift[15:0]};
            MEMOP_HU: rdata_o = {16'h0000, rshift[15:0]};
            // word accesses are always aligned
            default:  rdata_o = rdata_i;
        endcase
    end

    // lanes touched before the offset is applied
    always_comb begin
        case (memop_i)
            MEMOP_B,
            MEMOP_BU: lane_mask = 4'b0001;
            MEMOP_H,
            MEMOP_HU: lane_mask = 4'b0011;
            default:  lane_mask = 4'b1111;
        endcase
    end

    assign mask_o  = lane_mask << byte_off_i;

    // store data moved up into its lanes
    assign sdata_o = sdata_i << {byte_off_i, 3'b000};

endmodule

//--- lsu/store_ring_buffer.sv
module store_ring_buffer #(
    parameter int DEPTH = lsu_pkg::SB_DEPTH
) (
    input  logic            clk,
    input  logic            rst,

    input  logic            enq_i,
    input  lsu_pkg::addr_t  enq_addr_i,
    input  lsu_pkg::word_t  enq_wdata_i,
    input  lsu_pkg::mask_t  enq_wmask_i,

    input  logic            deq_i,
    output lsu_pkg::addr_t  head_addr_o,
    output lsu_pkg::word_t  head_wdata_o,
    output lsu_pkg::mask_t  head_wmask_o,

    output logic            full_o,
    output logic            empty_o,

    input  lsu_pkg::addr_t  lookup_addr_i,
    output logic            hit_o,
    output lsu_pkg::word_t  hit_wdata_o,
    output lsu_pkg::mask_t  hit_wmask_o
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    addr_t            addr_q  [DEPTH];
    word_t            wdata_q [DEPTH];
    mask_t            wmask_q [DEPTH];
    logic [DEPTH-1:0] valid_q;

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    assign head_addr_o  = addr_q[head_q];
    assign head_wdata_o = wdata_q[head_q];
    assign head_wmask_o = wmask_q[head_q];

    // pointers, occupancy and slot valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
        end else begin
            if (enq_i) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (deq_i) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            case ({enq_i, deq_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (enq_i) begin
            addr_q[tail_q]  <= enq_addr_i;
            wdata_q[tail_q] <= enq_wdata_i;
            wmask_q[tail_q] <= enq_wmask_i;
        end
    end

    // walk oldest to youngest, later matches overwrite their lanes
    always_comb begin
        logic [PTR_W-1:0] idx;

        idx         = head_q;
        hit_o       = 1'b0;
        hit_wdata_o = '0;
        hit_wmask_o = '0;
        for (int k = 0; k < DEPTH; k++) begin
            idx = head_q + PTR_W'(k);
            if (valid_q[idx] && (addr_q[idx][31:2] == lookup_addr_i[31:2])) begin
                hit_o = 1'b1;
                for (int j = 0; j < 4; j++) begin
                    if (wmask_q[idx][j]) begin
                        hit_wdata_o[8*j +: 8] = wdata_q[idx][8*j +: 8];
                        hit_wmask_o[j]        = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- common/lsu_pkg.sv
package lsu_pkg;

    // data path widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  mask_t;

    // issue tag carried from operation to result
    localparam int TAG_W = 5;
    typedef logic [TAG_W-1:0] tag_t;

    // access width, same encoding as RV32I funct3
    typedef logic [2:0] memop_t;

    localparam memop_t MEMOP_B  = 3'b000;
    localparam memop_t MEMOP_H  = 3'b001;
    localparam memop_t MEMOP_W  = 3'b010;
    localparam memop_t MEMOP_BU = 3'b100;
    localparam memop_t MEMOP_HU = 3'b101;

    // store buffer size at the top level
    // small enough that a short burst of stores fills it
    localparam int SB_DEPTH = 4;

    typedef logic [$clog2(SB_DEPTH)-1:0] sb_idx_t;

    // load/store unit FSM
    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD_WAIT,
        S_DRAIN_WAIT,
        S_RESULT
    } lsu_state_e;

endpackage
